// ==== hdl/msu_pkg.sv ====
package msu_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [13:0] msu_buf_addr_t;
  typedef logic [7:0]  msu_byte_t;
  typedef logic [2:0]  msu_reg_sel_t;
  typedef logic [31:0] msu_seek_t;
  typedef logic [15:0] msu_track_t;

  // Audio busy, data busy, volume, audio status hi/lo, ctrl start
  typedef logic [5:0]  msu_flags_t;

  localparam int MSU_FLAG_AUDIO_BUSY = 5;
  localparam int MSU_FLAG_DATA_BUSY  = 4;
  localparam int MSU_FLAG_CTRL_START = 0;

  localparam int MSU_BUF_DEPTH   = 16384;
  // High samples needed before a read strobe fall counts
  localparam int MSU_OE_HIGH_MIN = 5;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam msu_reg_sel_t MSU_REG_STATUS = 3'd0;
  localparam msu_reg_sel_t MSU_REG_DATA   = 3'd1;
  localparam msu_reg_sel_t MSU_REG_VOLUME = 3'd6;
  localparam msu_reg_sel_t MSU_REG_CTRL   = 3'd7;

  localparam logic [3:0] MSU_STATUS_LOW = 4'b0001;

  // "S-MSU1" on registers 2 to 7
  localparam msu_byte_t [0:5] MSU_ID_BYTES = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};

  typedef struct packed {
    msu_flags_t set_bits;
    msu_flags_t reset_bits;
  } msu_status_upd_t;

  typedef struct packed {
    logic we_rise;
    logic oe_fall;
    logic status_strobe;
  } msu_bus_evt_t;

endpackage

// ==== hdl/msu_bus_sync.sv ====
`timescale 1ns/1ps

module msu_bus_sync (
  input  logic                  clkin,
  input  logic                  arst_n,
  input  logic                  reg_we,
  input  logic                  reg_oe,
  input  logic                  status_reset_we,
  output msu_pkg::msu_bus_evt_t bus_evt
);
  import msu_pkg::*;

  // Two-flop synchronizers, one per strobe
  logic [1:0] we_sync;
  logic [1:0] oe_sync;
  logic [1:0] st_sync;

  // Sample history behind the synchronizers, newest in bit 0
  logic                       we_hist;
  logic                       st_hist;
  logic [MSU_OE_HIGH_MIN-1:0] oe_hist;

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      we_sync <= '0;
      oe_sync <= '0;
      st_sync <= '0;
      we_hist <= 1'b0;
      st_hist <= 1'b0;
      oe_hist <= '0;
      bus_evt <= '0;
    end else begin
      we_sync <= {we_sync[0], reg_we};
      oe_sync <= {oe_sync[0], reg_oe};
      st_sync <= {st_sync[0], status_reset_we};

      we_hist <= we_sync[1];
      st_hist <= st_sync[1];
      oe_hist <= {oe_hist[MSU_OE_HIGH_MIN-2:0], oe_sync[1]};

      bus_evt.we_rise       <= we_sync[1] & ~we_hist;
      bus_evt.status_strobe <= st_sync[1] & ~st_hist;
      // Fall only after a full run of highs, short glitches are dropped
      bus_evt.oe_fall       <= (&oe_hist) & ~oe_sync[1];
    end
  end

endmodule

// ==== hdl/msu_databuf.sv ====
`timescale 1ns/1ps

module msu_databuf (
  input  logic                   clkin,
  input  logic                   pgm_we_n,
  input  msu_pkg::msu_buf_addr_t pgm_address,
  input  msu_pkg::msu_byte_t     pgm_data,
  input  msu_pkg::msu_buf_addr_t buf_addr,
  output msu_pkg::msu_byte_t     buf_data
);
  import msu_pkg::*;

  msu_byte_t mem [MSU_BUF_DEPTH];

  ////////////////////////////////////////
  // Programming port
  ////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (!pgm_we_n) begin
      mem[pgm_address] <= pgm_data;
    end
  end

  ////////////////////////////////////////
  // Read port, one cycle latency
  ////////////////////////////////////////

  always_ff @(posedge clkin) begin
    buf_data <= mem[buf_addr];
  end

endmodule

// ==== hdl/msu_regs.sv ====
`timescale 1ns/1ps

module msu_regs (
  input  logic                     clkin,
  input  logic                     arst_n,
  input  logic                     enable,
  input  msu_pkg::msu_bus_evt_t    bus_evt,
  input  msu_pkg::msu_reg_sel_t    reg_addr,
  input  msu_pkg::msu_byte_t       reg_data_in,
  input  msu_pkg::msu_status_upd_t status_upd,
  input  msu_pkg::msu_byte_t       buf_data,
  output msu_pkg::msu_buf_addr_t   buf_addr,
  output msu_pkg::msu_byte_t       reg_data_out,
  output logic [6:0]               status_out,
  output msu_pkg::msu_byte_t       volume_out,
  output logic                     volume_latch_out,
  output msu_pkg::msu_seek_t       addr_out,
  output msu_pkg::msu_track_t      track_out
);
  import msu_pkg::*;

  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic [1:0] audio_ctrl;
  logic [1:0] audio_status;

  msu_buf_addr_t ptr;
  msu_byte_t     data_r;
  msu_reg_sel_t  id_idx;

  logic reg_wr;
  logic data_rd;

  assign reg_wr  = bus_evt.we_rise & enable;
  assign data_rd = bus_evt.oe_fall & enable & (reg_addr == MSU_REG_DATA);

  ////////////////////////////////////////
  // Register writes and status flags
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      addr_out         <= '0;
      track_out        <= '0;
      volume_out       <= '0;
      volume_latch_out <= 1'b0;
      audio_ctrl       <= '0;
      audio_status     <= '0;
      audio_start      <= 1'b0;
      data_start       <= 1'b0;
      ctrl_start       <= 1'b0;
      audio_busy       <= 1'b1;
      data_busy        <= 1'b1;
    end else begin
      volume_latch_out <= 1'b0;
      // Console write wins over a firmware status update
      if (reg_wr) begin
        case (reg_addr)
          3'd0: addr_out[7:0]   <= reg_data_in;
          3'd1: addr_out[15:8]  <= reg_data_in;
          3'd2: addr_out[23:16] <= reg_data_in;
          3'd3: begin
            addr_out[31:24] <= reg_data_in;
            data_start      <= 1'b1;
            data_busy       <= 1'b1;
          end
          3'd4: track_out[7:0] <= reg_data_in;
          3'd5: begin
            track_out[15:8] <= reg_data_in;
            audio_start     <= 1'b1;
            audio_busy      <= 1'b1;
          end
          MSU_REG_VOLUME: begin
            volume_out       <= reg_data_in;
            volume_latch_out <= 1'b1;
          end
          MSU_REG_CTRL: begin
            // Play control is locked out while a track is loading
            if (!audio_busy) begin
              audio_ctrl <= reg_data_in[1:0];
              ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (bus_evt.status_strobe) begin
        audio_busy <= (audio_busy | status_upd.set_bits[MSU_FLAG_AUDIO_BUSY])
                      & ~status_upd.reset_bits[MSU_FLAG_AUDIO_BUSY];
        data_busy  <= (data_busy | status_upd.set_bits[MSU_FLAG_DATA_BUSY])
                      & ~status_upd.reset_bits[MSU_FLAG_DATA_BUSY];
        audio_status <= (audio_status | status_upd.set_bits[2:1])
                        & ~status_upd.reset_bits[2:1];
        ctrl_start <= (ctrl_start | status_upd.set_bits[MSU_FLAG_CTRL_START])
                      & ~status_upd.reset_bits[MSU_FLAG_CTRL_START];
        // Start flags are only ever cleared from this side
        if (status_upd.reset_bits[MSU_FLAG_AUDIO_BUSY]) begin
          audio_start <= 1'b0;
        end
        if (status_upd.reset_bits[MSU_FLAG_DATA_BUSY]) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Data port pointer
  ////////////////////////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (data_rd) begin
      ptr <= ptr + 1'b1;
    end
  end

  assign buf_addr = ptr;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  assign id_idx = reg_addr - 3'd2;

  always_ff @(posedge clkin) begin
    // Buffer output has settled since the last pointer step
    if (data_rd) begin
      data_r <= buf_data;
    end
    case (reg_addr)
      MSU_REG_STATUS: reg_data_out <= {data_busy, audio_busy, audio_status, MSU_STATUS_LOW};
      MSU_REG_DATA:   reg_data_out <= data_r;
      default:        reg_data_out <= MSU_ID_BYTES[id_idx];
    endcase
  end

  assign status_out = {ptr[13], audio_start, data_start, volume_latch_out,
                       audio_ctrl, ctrl_start};

endmodule

// ==== hdl/msu_top.sv ====
`timescale 1ns/1ps

module msu_top (
  input  logic                   clkin,
  input  logic                   arst_n,
  input  logic                   enable,
  // Console bus
  input  msu_pkg::msu_reg_sel_t  reg_addr,
  input  msu_pkg::msu_byte_t     reg_data_in,
  input  logic                   reg_we,
  input  logic                   reg_oe,
  output msu_pkg::msu_byte_t     reg_data_out,
  // Programming port
  input  msu_pkg::msu_buf_addr_t pgm_address,
  input  msu_pkg::msu_byte_t     pgm_data,
  input  logic                   pgm_we_n,
  // Firmware status port
  input  msu_pkg::msu_flags_t    status_reset_bits,
  input  msu_pkg::msu_flags_t    status_set_bits,
  input  logic                   status_reset_we,
  output logic [6:0]             status_out,
  // Decoded register state
  output msu_pkg::msu_byte_t     volume_out,
  output logic                   volume_latch_out,
  output msu_pkg::msu_seek_t     addr_out,
  output msu_pkg::msu_track_t    track_out
);
  import msu_pkg::*;

  msu_bus_evt_t    bus_evt;
  msu_status_upd_t status_upd;
  msu_buf_addr_t   buf_addr;
  msu_byte_t       buf_data;

  assign status_upd.set_bits   = status_set_bits;
  assign status_upd.reset_bits = status_reset_bits;

  msu_bus_sync sync_i (
    .clkin           (clkin),
    .arst_n          (arst_n),
    .reg_we          (reg_we),
    .reg_oe          (reg_oe),
    .status_reset_we (status_reset_we),
    .bus_evt         (bus_evt)
  );

  msu_regs regs_i (
    .clkin            (clkin),
    .arst_n           (arst_n),
    .enable           (enable),
    .bus_evt          (bus_evt),
    .reg_addr         (reg_addr),
    .reg_data_in      (reg_data_in),
    .status_upd       (status_upd),
    .buf_data         (buf_data),
    .buf_addr         (buf_addr),
    .reg_data_out     (reg_data_out),
    .status_out       (status_out),
    .volume_out       (volume_out),
    .volume_latch_out (volume_latch_out),
    .addr_out         (addr_out),
    .track_out        (track_out)
  );

  msu_databuf databuf_i (
    .clkin       (clkin),
    .pgm_we_n    (pgm_we_n),
    .pgm_address (pgm_address),
    .pgm_data    (pgm_data),
    .buf_addr    (buf_addr),
    .buf_data    (buf_data)
  );

endmodule

// ==== include/msu_tb_model.svh ====
`ifndef MSU_TB_MODEL_SVH
`define MSU_TB_MODEL_SVH

// Expected register state
msu_pkg::msu_seek_t     m_addr;
msu_pkg::msu_track_t    m_track;
msu_pkg::msu_byte_t     m_volume;
logic [1:0]             m_ctrl;
logic [1:0]             m_audio_status;
logic                   m_audio_start;
logic                   m_data_start;
logic                   m_ctrl_start;
logic                   m_audio_busy;
logic                   m_data_busy;
msu_pkg::msu_buf_addr_t m_ptr;
// Shadow of the data buffer
msu_pkg::msu_byte_t     m_buf [msu_pkg::MSU_BUF_DEPTH];

task automatic reset_model();
  m_addr         = '0;
  m_track        = '0;
  m_volume       = '0;
  m_ctrl         = '0;
  m_audio_status = '0;
  m_audio_start  = 1'b0;
  m_data_start   = 1'b0;
  m_ctrl_start   = 1'b0;
  m_audio_busy   = 1'b1;
  m_data_busy    = 1'b1;
  m_ptr          = '0;
endtask

task automatic record_write(input msu_pkg::msu_reg_sel_t a, input msu_pkg::msu_byte_t d);
  case (a)
    3'd0: m_addr[7:0]   = d;
    3'd1: m_addr[15:8]  = d;
    3'd2: m_addr[23:16] = d;
    3'd3: begin
      m_addr[31:24] = d;
      m_data_start  = 1'b1;
      m_data_busy   = 1'b1;
    end
    3'd4: m_track[7:0] = d;
    3'd5: begin
      m_track[15:8] = d;
      m_audio_start = 1'b1;
      m_audio_busy  = 1'b1;
    end
    3'd6: m_volume = d;
    default: begin
      if (!m_audio_busy) begin
        m_ctrl       = d[1:0];
        m_ctrl_start = 1'b1;
      end
    end
  endcase
endtask

task automatic update_flags(input msu_pkg::msu_flags_t set_b,
                            input msu_pkg::msu_flags_t rst_b);
  m_audio_busy   = (m_audio_busy | set_b[5]) & ~rst_b[5];
  m_data_busy    = (m_data_busy | set_b[4]) & ~rst_b[4];
  m_audio_status = (m_audio_status | set_b[2:1]) & ~rst_b[2:1];
  m_ctrl_start   = (m_ctrl_start | set_b[0]) & ~rst_b[0];
  if (rst_b[5]) begin
    m_audio_start = 1'b0;
  end
  if (rst_b[4]) begin
    m_data_start = 1'b0;
  end
endtask

// Byte the data port returns, then advance
task automatic next_data_byte(output msu_pkg::msu_byte_t d);
  d     = m_buf[m_ptr];
  m_ptr = m_ptr + 1'b1;
endtask

function automatic msu_pkg::msu_byte_t reg0_expected();
  return {m_data_busy, m_audio_busy, m_audio_status, msu_pkg::MSU_STATUS_LOW};
endfunction

// Volume latch is a single-cycle pulse, so zero when idle
function automatic logic [6:0] status_out_expected();
  return {m_ptr[13], m_audio_start, m_data_start, 1'b0, m_ctrl, m_ctrl_start};
endfunction

`endif

// ==== verification/msu_tb.sv ====
`timescale 1ns/1ps

module msu_tb;
  import msu_pkg::*;

  localparam int CLK_HALF     = 50;
  localparam int DRIVE_DELAY  = 5;
  localparam int WRITE_CYCLES = 8;
  localparam int READ_CYCLES  = 12;
  localparam int NUM_RAND     = 24;
  localparam int NUM_READS    = 8192 + 8;
  // Buffer fill and data reads dominate, the register tests get a fixed allowance
  localparam int TEST_CYCLES    = MSU_BUF_DEPTH + NUM_READS * READ_CYCLES + 100 * WRITE_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  localparam logic [47:0] ID_STR = "S-MSU1";

  logic          clkin;
  logic          arst_n;
  logic          enable;
  msu_reg_sel_t  reg_addr;
  msu_byte_t     reg_data_in;
  logic          reg_we;
  logic          reg_oe;
  msu_byte_t     reg_data_out;
  msu_buf_addr_t pgm_address;
  msu_byte_t     pgm_data;
  logic          pgm_we_n;
  msu_flags_t    status_reset_bits;
  msu_flags_t    status_set_bits;
  logic          status_reset_we;
  logic [6:0]    status_out;
  msu_byte_t     volume_out;
  logic          volume_latch_out;
  msu_seek_t     addr_out;
  msu_track_t    track_out;

  integer seed;
  int     errors;
  int     checks;
  int     errs_at_start;
  int     latch_count;
  int     status_latch_count;
  int     cycles;

  `include "msu_tb_model.svh"

  msu_top dut_i (.*);

  initial clkin = 1'b0;
  always #CLK_HALF clkin = ~clkin;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Step n clocks, landing just after the rising edge
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clkin);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // Counts volume latch pulses over the whole strobe
  task automatic reg_write(input msu_reg_sel_t a, input msu_byte_t d);
    reg_addr           = a;
    reg_data_in        = d;
    reg_we             = 1'b1;
    latch_count        = 0;
    status_latch_count = 0;
    repeat (WRITE_CYCLES / 2) begin
      tick(1);
      latch_count        += int'(volume_latch_out);
      status_latch_count += int'(status_out[3]);
    end
    reg_we = 1'b0;
    repeat (WRITE_CYCLES / 2) begin
      tick(1);
      latch_count        += int'(volume_latch_out);
      status_latch_count += int'(status_out[3]);
    end
    if (enable) record_write(a, d);
  endtask

  task automatic reg_read(input msu_reg_sel_t a, output msu_byte_t d);
    reg_addr = a;
    tick(2);
    d = reg_data_out;
  endtask

  // Read strobe high long enough to pass the glitch filter
  task automatic data_read(output msu_byte_t d);
    reg_addr = MSU_REG_DATA;
    reg_oe   = 1'b1;
    tick(READ_CYCLES / 2);
    reg_oe = 1'b0;
    tick(READ_CYCLES / 2);
    d = reg_data_out;
  endtask

  task automatic status_update(input msu_flags_t set_b, input msu_flags_t rst_b);
    status_set_bits   = set_b;
    status_reset_bits = rst_b;
    status_reset_we   = 1'b1;
    tick(4);
    status_reset_we = 1'b0;
    tick(4);
    update_flags(set_b, rst_b);
  endtask

  task automatic check_outputs();
    msu_byte_t r;
    check("addr_out", addr_out, m_addr);
    check("track_out", track_out, m_track);
    check("volume_out", volume_out, m_volume);
    check("status_out", status_out, status_out_expected());
    reg_read(MSU_REG_STATUS, r);
    check("reg_data_out", r, reg0_expected());
  endtask

  task automatic test_done(input string name);
    $display("Test %s finished with %0d errors", name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  ////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clkin);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial begin
    msu_byte_t d;
    msu_byte_t exp_b;
    seed               = 41;
    errors             = 0;
    checks             = 0;
    errs_at_start      = 0;
    latch_count        = 0;
    status_latch_count = 0;
    arst_n             = 1'b0;
    enable             = 1'b1;
    reg_addr           = '0;
    reg_data_in        = '0;
    reg_we             = 1'b0;
    reg_oe             = 1'b0;
    pgm_address        = '0;
    pgm_data           = '0;
    pgm_we_n           = 1'b1;
    status_reset_bits  = '0;
    status_set_bits    = '0;
    status_reset_we    = 1'b0;
    reset_model();
    tick(3);
    arst_n = 1'b1;
    tick(2);

    // Reset values and ID string
    reg_read(MSU_REG_STATUS, d);
    check("reg_data_out", d, 8'hC1);
    check("status_out", status_out, 7'h00);
    for (int i = 2; i < 8; i++) begin
      reg_read(msu_reg_sel_t'(i), d);
      check("reg_data_out", d, ID_STR[47 - 8 * (i - 2) -: 8]);
    end
    check_outputs();
    test_done("reset_id");

    // Seek address and track
    for (int i = 0; i < 6; i++) begin
      reg_write(msu_reg_sel_t'(i), msu_byte_t'($random(seed)));
      if (i == 3) check("status_out[4]", status_out[4], 1'b1);
      if (i == 5) check("status_out[5]", status_out[5], 1'b1);
    end
    check_outputs();
    reg_read(MSU_REG_STATUS, d);
    check("reg_data_out[7:6]", d[7:6], 2'b11);
    test_done("seek_track");

    // Volume and its one-cycle latch
    reg_write(MSU_REG_VOLUME, msu_byte_t'($random(seed)));
    check("volume_latch_out pulses", latch_count, 1);
    check("status_out[3] pulses", status_latch_count, 1);
    check_outputs();
    test_done("volume");

    // Control is locked while audio is busy
    reg_write(MSU_REG_CTRL, msu_byte_t'($random(seed)));
    check("status_out[0]", status_out[0], 1'b0);
    check_outputs();
    status_update(6'b000000, 6'b100000);
    check_outputs();
    reg_write(MSU_REG_CTRL, msu_byte_t'($random(seed)));
    check("status_out[0]", status_out[0], 1'b1);
    check_outputs();
    for (int i = 0; i < NUM_RAND; i++) begin
      status_update(msu_flags_t'($random(seed)), msu_flags_t'($random(seed)));
      check_outputs();
    end
    test_done("control_status");

    // Fill the whole buffer, then stream it back
    for (int a = 0; a < MSU_BUF_DEPTH; a++) begin
      m_buf[a]    = msu_byte_t'($random(seed));
      pgm_address = msu_buf_addr_t'(a);
      pgm_data    = m_buf[a];
      pgm_we_n    = 1'b0;
      tick(1);
    end
    pgm_we_n = 1'b1;
    tick(1);
    for (int i = 0; i < NUM_READS; i++) begin
      data_read(d);
      next_data_byte(exp_b);
      check("reg_data_out", d, exp_b);
      check("status_out[6]", status_out[6], m_ptr[13]);
    end
    check("status_out[6]", status_out[6], 1'b1);
    test_done("data_port");

    // Nothing moves while disabled
    enable = 1'b0;
    for (int i = 0; i < 8; i++) begin
      reg_write(msu_reg_sel_t'(i), msu_byte_t'($random(seed)));
      if (i == 6) begin
        check("volume_latch_out pulses", latch_count, 0);
        check("status_out[3] pulses", status_latch_count, 0);
      end
    end
    data_read(d);
    check_outputs();
    enable = 1'b1;
    data_read(d);
    next_data_byte(exp_b);
    check("reg_data_out", d, exp_b);
    test_done("enable");

    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== msu_top.f ====
+incdir+include
hdl/msu_pkg.sv
hdl/msu_bus_sync.sv
hdl/msu_databuf.sv
hdl/msu_regs.sv
hdl/msu_top.sv
verification/msu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module msu_tb -f msu_top.f -o msu_sim

out=$(./obj_dir/msu_sim)
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
  exit 0
fi
exit 1
